// File: hw/llc_config.svh
`ifndef LLC_CONFIG_SVH
`define LLC_CONFIG_SVH

// set index and its split into bank and row
`define LLC_SET_BITS    4
`define LLC_SETS        16
`define LLC_BANK_BITS   1
`define LLC_BANKS       (1 << `LLC_BANK_BITS)
`define LLC_IDX_BITS    (`LLC_SET_BITS - `LLC_BANK_BITS)
`define LLC_BANK_SETS   (1 << `LLC_IDX_BITS)

// ways, kept in even/odd pairs
`define LLC_WAYS        4
`define LLC_WAY_BITS    2

// per-way field widths
`define LLC_TAG_BITS    8
`define LLC_LINE_BITS   64
`define LLC_NUM_CPUS    4
`define LLC_OWNER_BITS  2
`define LLC_STATE_BITS  3

// block RAM word and line split
`define BRAM_WORD_BITS  32
`define LINE_WORDS      (`LLC_LINE_BITS / `BRAM_WORD_BITS)

`endif

// File: hw/llc_pkg.sv
`default_nettype none

`include "llc_config.svh"

package llc_pkg;

    typedef logic [`LLC_SET_BITS-1:0]   llc_set_t;
    typedef logic [`LLC_WAY_BITS-1:0]   llc_way_t;
    typedef logic [`LLC_TAG_BITS-1:0]   llc_tag_t;
    typedef logic [`LLC_LINE_BITS-1:0]  line_t;

    // one bit per cpu
    typedef logic [`LLC_NUM_CPUS-1:0]   sharers_t;
    typedef logic [`LLC_OWNER_BITS-1:0] owner_t;
    typedef logic                       hprot_t;

    // coherence state, invalid must stay zero for the flush
    typedef enum logic [`LLC_STATE_BITS-1:0] {
        invalid   = 3'd0,
        valid     = 3'd1,
        shared    = 3'd2,
        exclusive = 3'd3,
        modified  = 3'd4
    } llc_state_t;

endpackage

`default_nettype wire

// File: hw/llc_bram_2p.sv
`timescale 1ns/1ns
`default_nettype none

// true dual-port block RAM, read-first
module llc_bram_2p #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16
) (
    input  logic                     clk,
    input  logic [$clog2(DEPTH)-1:0] a0,
    input  logic [$clog2(DEPTH)-1:0] a1,
    input  logic [WIDTH-1:0]         d0,
    input  logic [WIDTH-1:0]         d1,
    input  logic                     we0,
    input  logic                     we1,
    input  logic                     ce0,
    input  logic                     ce1,
    output logic [WIDTH-1:0]         q0,
    output logic [WIDTH-1:0]         q1
);

    logic [WIDTH-1:0] mem [DEPTH];

    // ce only steers the output registers, so a write with no
    // read pending leaves the last read word in place
    always_ff @(posedge clk) begin
        if (we0) begin
            mem[a0] <= d0;
        end
        if (ce0) begin
            q0 <= mem[a0];
        end
        if (we1) begin
            mem[a1] <= d1;
        end
        if (ce1) begin
            q1 <= mem[a1];
        end
    end

endmodule

`default_nettype wire

// File: hw/llc_way_pair_mem.sv
`timescale 1ns/1ns
`default_nettype none

`include "llc_config.svh"

module llc_way_pair_mem (
    input  logic                   clk,
    input  llc_pkg::llc_set_t      set,
    input  logic                   rd_en,
    input  logic                   we_even,
    input  logic                   we_odd,
    input  logic [`LLC_BANKS-1:0]  we_tag_bank,
    input  logic [`LLC_BANKS-1:0]  we_state_bank,
    input  logic [`LLC_BANKS-1:0]  we_sharers_bank,
    input  logic [`LLC_BANKS-1:0]  we_owner_bank,
    input  logic [`LLC_BANKS-1:0]  we_hprot_bank,
    input  logic [`LLC_BANKS-1:0]  we_dirty_bank,
    input  logic [`LLC_BANKS-1:0]  we_line_bank,
    input  llc_pkg::line_t         wr_data_line,
    input  llc_pkg::llc_tag_t      wr_data_tag,
    input  llc_pkg::sharers_t      wr_data_sharers,
    input  llc_pkg::owner_t        wr_data_owner,
    input  llc_pkg::hprot_t        wr_data_hprot,
    input  logic                   wr_data_dirty_bit,
    input  llc_pkg::llc_state_t    wr_data_state,
    output llc_pkg::line_t         rd_data_line [2],
    output llc_pkg::llc_tag_t      rd_data_tag [2],
    output llc_pkg::sharers_t      rd_data_sharers [2],
    output llc_pkg::owner_t        rd_data_owner [2],
    output llc_pkg::hprot_t        rd_data_hprot [2],
    output logic                   rd_data_dirty_bit [2],
    output llc_pkg::llc_state_t    rd_data_state [2]
);
    import llc_pkg::*;

    localparam int W         = `BRAM_WORD_BITS;
    localparam int RAM_DEPTH = 2 * `LLC_BANK_SETS;

    logic [`LLC_IDX_BITS-1:0]   idx;
    logic [`LLC_IDX_BITS:0]     addr_even;
    logic [`LLC_IDX_BITS:0]     addr_odd;
    logic [`LLC_BANK_BITS-1:0]  bank_q;

    // raw RAM outputs, [bank][even/odd]
    llc_tag_t                   tag_q     [`LLC_BANKS][2];
    logic [`LLC_STATE_BITS-1:0] state_q   [`LLC_BANKS][2];
    sharers_t                   sharers_q [`LLC_BANKS][2];
    owner_t                     owner_q   [`LLC_BANKS][2];
    hprot_t                     hprot_q   [`LLC_BANKS][2];
    logic                       dirty_q   [`LLC_BANKS][2];
    logic [W-1:0]               line_q    [`LLC_BANKS][2][`LINE_WORDS];

    assign idx = set[`LLC_IDX_BITS-1:0];

    // even way in the lower half of each RAM, odd way in the upper half
    assign addr_even = {1'b0, idx};
    assign addr_odd  = {1'b1, idx};

    // bank of the last read, so the mux follows the read and not the current set
    always_ff @(posedge clk) begin
        if (rd_en) begin
            bank_q <= set[`LLC_SET_BITS-1 -: `LLC_BANK_BITS];
        end
    end

    for (genvar b = 0; b < `LLC_BANKS; b++) begin : g_bank
        llc_bram_2p #(.WIDTH(`LLC_TAG_BITS), .DEPTH(RAM_DEPTH)) u_tag (
            .clk(clk), .a0(addr_even), .a1(addr_odd),
            .d0(wr_data_tag), .d1(wr_data_tag),
            .we0(we_even & we_tag_bank[b]), .we1(we_odd & we_tag_bank[b]),
            .ce0(rd_en), .ce1(rd_en), .q0(tag_q[b][0]), .q1(tag_q[b][1])
        );
        llc_bram_2p #(.WIDTH(`LLC_STATE_BITS), .DEPTH(RAM_DEPTH)) u_state (
            .clk(clk), .a0(addr_even), .a1(addr_odd),
            .d0(wr_data_state), .d1(wr_data_state),
            .we0(we_even & we_state_bank[b]), .we1(we_odd & we_state_bank[b]),
            .ce0(rd_en), .ce1(rd_en), .q0(state_q[b][0]), .q1(state_q[b][1])
        );
        llc_bram_2p #(.WIDTH(`LLC_NUM_CPUS), .DEPTH(RAM_DEPTH)) u_sharers (
            .clk(clk), .a0(addr_even), .a1(addr_odd),
            .d0(wr_data_sharers), .d1(wr_data_sharers),
            .we0(we_even & we_sharers_bank[b]), .we1(we_odd & we_sharers_bank[b]),
            .ce0(rd_en), .ce1(rd_en), .q0(sharers_q[b][0]), .q1(sharers_q[b][1])
        );
        llc_bram_2p #(.WIDTH(`LLC_OWNER_BITS), .DEPTH(RAM_DEPTH)) u_owner (
            .clk(clk), .a0(addr_even), .a1(addr_odd),
            .d0(wr_data_owner), .d1(wr_data_owner),
            .we0(we_even & we_owner_bank[b]), .we1(we_odd & we_owner_bank[b]),
            .ce0(rd_en), .ce1(rd_en), .q0(owner_q[b][0]), .q1(owner_q[b][1])
        );
        llc_bram_2p #(.WIDTH(1), .DEPTH(RAM_DEPTH)) u_hprot (
            .clk(clk), .a0(addr_even), .a1(addr_odd),
            .d0(wr_data_hprot), .d1(wr_data_hprot),
            .we0(we_even & we_hprot_bank[b]), .we1(we_odd & we_hprot_bank[b]),
            .ce0(rd_en), .ce1(rd_en), .q0(hprot_q[b][0]), .q1(hprot_q[b][1])
        );
        llc_bram_2p #(.WIDTH(1), .DEPTH(RAM_DEPTH)) u_dirty (
            .clk(clk), .a0(addr_even), .a1(addr_odd),
            .d0(wr_data_dirty_bit), .d1(wr_data_dirty_bit),
            .we0(we_even & we_dirty_bank[b]), .we1(we_odd & we_dirty_bank[b]),
            .ce0(rd_en), .ce1(rd_en), .q0(dirty_q[b][0]), .q1(dirty_q[b][1])
        );
        // a line spans several RAM words
        for (genvar k = 0; k < `LINE_WORDS; k++) begin : g_word
            llc_bram_2p #(.WIDTH(W), .DEPTH(RAM_DEPTH)) u_line (
                .clk(clk), .a0(addr_even), .a1(addr_odd),
                .d0(wr_data_line[k*W +: W]), .d1(wr_data_line[k*W +: W]),
                .we0(we_even & we_line_bank[b]), .we1(we_odd & we_line_bank[b]),
                .ce0(rd_en), .ce1(rd_en), .q0(line_q[b][0][k]), .q1(line_q[b][1][k])
            );
        end
    end

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            rd_data_tag[w]       = tag_q[bank_q][w];
            rd_data_state[w]     = llc_state_t'(state_q[bank_q][w]);
            rd_data_sharers[w]   = sharers_q[bank_q][w];
            rd_data_owner[w]     = owner_q[bank_q][w];
            rd_data_hprot[w]     = hprot_q[bank_q][w];
            rd_data_dirty_bit[w] = dirty_q[bank_q][w];
            for (int k = 0; k < `LINE_WORDS; k++) begin
                rd_data_line[w][k*W +: W] = line_q[bank_q][w][k];
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/llc_localmem.sv
`timescale 1ns/1ns
`default_nettype none

`include "llc_config.svh"

module llc_localmem (
    input  logic                   clk,
    input  llc_pkg::llc_set_t      set,
    input  llc_pkg::llc_way_t      way,
    input  logic                   rd_en,
    input  logic                   wr_en,
    input  logic                   wr_en_evict_way,
    input  logic [`LLC_WAYS-1:0]   wr_rst_flush,
    input  llc_pkg::line_t         wr_data_line,
    input  llc_pkg::llc_tag_t      wr_data_tag,
    input  llc_pkg::sharers_t      wr_data_sharers,
    input  llc_pkg::owner_t        wr_data_owner,
    input  llc_pkg::hprot_t        wr_data_hprot,
    input  logic                   wr_data_dirty_bit,
    input  llc_pkg::llc_way_t      wr_data_evict_way,
    input  llc_pkg::llc_state_t    wr_data_state,
    output llc_pkg::line_t         rd_data_line [`LLC_WAYS],
    output llc_pkg::llc_tag_t      rd_data_tag [`LLC_WAYS],
    output llc_pkg::sharers_t      rd_data_sharers [`LLC_WAYS],
    output llc_pkg::owner_t        rd_data_owner [`LLC_WAYS],
    output llc_pkg::hprot_t        rd_data_hprot [`LLC_WAYS],
    output logic                   rd_data_dirty_bit [`LLC_WAYS],
    output llc_pkg::llc_way_t      rd_data_evict_way,
    output llc_pkg::llc_state_t    rd_data_state [`LLC_WAYS]
);

    logic [`LLC_WAYS-1:0]  wr_en_port;
    logic [`LLC_BANKS-1:0] bank_sel;
    logic [`LLC_BANKS-1:0] we_meta_bank;
    logic [`LLC_BANKS-1:0] we_data_bank;
    logic                  flush_any;

    assign flush_any = |wr_rst_flush;

    // addressed way on a write, every masked way during a flush
    always_comb begin
        for (int i = 0; i < `LLC_WAYS; i++) begin
            wr_en_port[i] = (wr_en && (way == i[`LLC_WAY_BITS-1:0])) || wr_rst_flush[i];
        end
    end

    // state, sharers and dirty are also cleared by the flush
    always_comb begin
        for (int b = 0; b < `LLC_BANKS; b++) begin
            bank_sel[b]     = (set[`LLC_SET_BITS-1 -: `LLC_BANK_BITS] == b[`LLC_BANK_BITS-1:0]);
            we_data_bank[b] = bank_sel[b] & wr_en;
            we_meta_bank[b] = bank_sel[b] & (wr_en | flush_any);
        end
    end

    for (genvar p = 0; p < `LLC_WAYS / 2; p++) begin : g_pair
        llc_way_pair_mem u_pair (
            .clk               (clk),
            .set               (set),
            .rd_en             (rd_en),
            .we_even           (wr_en_port[2*p]),
            .we_odd            (wr_en_port[2*p+1]),
            .we_tag_bank       (we_data_bank),
            .we_state_bank     (we_meta_bank),
            .we_sharers_bank   (we_meta_bank),
            .we_owner_bank     (we_data_bank),
            .we_hprot_bank     (we_data_bank),
            .we_dirty_bank     (we_meta_bank),
            .we_line_bank      (we_data_bank),
            .wr_data_line      (wr_data_line),
            .wr_data_tag       (wr_data_tag),
            .wr_data_sharers   (wr_data_sharers),
            .wr_data_owner     (wr_data_owner),
            .wr_data_hprot     (wr_data_hprot),
            .wr_data_dirty_bit (wr_data_dirty_bit),
            .wr_data_state     (wr_data_state),
            .rd_data_line      (rd_data_line[2*p:2*p+1]),
            .rd_data_tag       (rd_data_tag[2*p:2*p+1]),
            .rd_data_sharers   (rd_data_sharers[2*p:2*p+1]),
            .rd_data_owner     (rd_data_owner[2*p:2*p+1]),
            .rd_data_hprot     (rd_data_hprot[2*p:2*p+1]),
            .rd_data_dirty_bit (rd_data_dirty_bit[2*p:2*p+1]),
            .rd_data_state     (rd_data_state[2*p:2*p+1])
        );
    end

    // one eviction pointer per set, port 1 idle
    llc_bram_2p #(.WIDTH(`LLC_WAY_BITS), .DEPTH(`LLC_SETS)) u_evict_way (
        .clk(clk), .a0(set), .a1('0), .d0(wr_data_evict_way), .d1('0),
        .we0(wr_en_evict_way), .we1(1'b0), .ce0(rd_en), .ce1(1'b0),
        .q0(rd_data_evict_way), .q1()
    );

endmodule

`default_nettype wire

// File: hw/llc_flush_seq.sv
`timescale 1ns/1ns
`default_nettype none

`include "llc_config.svh"

module llc_flush_seq (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush_start,
    input  logic [`LLC_WAYS-1:0]  flush_ways,
    output llc_pkg::llc_set_t     flush_set,
    output logic [`LLC_WAYS-1:0]  wr_rst_flush,
    output logic                  flush_busy,
    output logic                  flush_done
);

    logic [`LLC_WAYS-1:0] ways_q;

    // one set per cycle, starting the cycle after the start pulse
    always_ff @(posedge clk) begin
        if (reset) begin
            flush_busy <= 1'b0;
            flush_done <= 1'b0;
            flush_set  <= '0;
            ways_q     <= '0;
        end else begin
            flush_done <= 1'b0;
            if (!flush_busy) begin
                if (flush_start) begin
                    flush_busy <= 1'b1;
                    flush_set  <= '0;
                    ways_q     <= flush_ways;
                end
            end else begin
                flush_set <= flush_set + 1'b1;
                // last set written at this edge
                if (flush_set == `LLC_SETS - 1) begin
                    flush_busy <= 1'b0;
                    flush_done <= 1'b1;
                end
            end
        end
    end

    // mask only while walking
    assign wr_rst_flush = flush_busy ? ways_q : '0;

endmodule

`default_nettype wire

// File: hw/llc_mem_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "llc_config.svh"

module llc_mem_top (
    input  logic                   clk,
    input  logic                   reset,
    input  llc_pkg::llc_set_t      set,
    input  llc_pkg::llc_way_t      way,
    input  logic                   rd_en,
    input  logic                   wr_en,
    input  logic                   wr_en_evict_way,
    input  llc_pkg::line_t         wr_data_line,
    input  llc_pkg::llc_tag_t      wr_data_tag,
    input  llc_pkg::sharers_t      wr_data_sharers,
    input  llc_pkg::owner_t        wr_data_owner,
    input  llc_pkg::hprot_t        wr_data_hprot,
    input  logic                   wr_data_dirty_bit,
    input  llc_pkg::llc_way_t      wr_data_evict_way,
    input  llc_pkg::llc_state_t    wr_data_state,
    input  logic                   flush_start,
    input  logic [`LLC_WAYS-1:0]   flush_ways,
    output llc_pkg::line_t         rd_data_line [`LLC_WAYS],
    output llc_pkg::llc_tag_t      rd_data_tag [`LLC_WAYS],
    output llc_pkg::sharers_t      rd_data_sharers [`LLC_WAYS],
    output llc_pkg::owner_t        rd_data_owner [`LLC_WAYS],
    output llc_pkg::hprot_t        rd_data_hprot [`LLC_WAYS],
    output logic                   rd_data_dirty_bit [`LLC_WAYS],
    output llc_pkg::llc_state_t    rd_data_state [`LLC_WAYS],
    output llc_pkg::llc_way_t      rd_data_evict_way,
    output logic                   flush_busy,
    output logic                   flush_done
);
    import llc_pkg::*;

    llc_set_t             flush_set;
    logic [`LLC_WAYS-1:0] wr_rst_flush;
    llc_set_t             mem_set;
    logic                 mem_rd_en;
    logic                 mem_wr_en;
    logic                 mem_wr_en_evict_way;
    llc_state_t           mem_wr_data_state;
    sharers_t             mem_wr_data_sharers;
    logic                 mem_wr_data_dirty_bit;

    // flush owns the set and the cleared fields while busy
    assign mem_set               = flush_busy ? flush_set : set;
    assign mem_rd_en             = rd_en & ~flush_busy;
    assign mem_wr_en             = wr_en & ~flush_busy;
    assign mem_wr_en_evict_way   = wr_en_evict_way & ~flush_busy;
    assign mem_wr_data_state     = flush_busy ? invalid : wr_data_state;
    assign mem_wr_data_sharers   = flush_busy ? '0 : wr_data_sharers;
    assign mem_wr_data_dirty_bit = wr_data_dirty_bit & ~flush_busy;

    llc_flush_seq u_flush_seq (
        .clk(clk), .reset(reset), .flush_start(flush_start), .flush_ways(flush_ways),
        .flush_set(flush_set), .wr_rst_flush(wr_rst_flush),
        .flush_busy(flush_busy), .flush_done(flush_done)
    );

    llc_localmem u_localmem (
        .clk(clk), .set(mem_set), .way(way), .rd_en(mem_rd_en), .wr_en(mem_wr_en),
        .wr_en_evict_way(mem_wr_en_evict_way), .wr_rst_flush(wr_rst_flush),
        .wr_data_line(wr_data_line), .wr_data_tag(wr_data_tag),
        .wr_data_sharers(mem_wr_data_sharers), .wr_data_owner(wr_data_owner),
        .wr_data_hprot(wr_data_hprot), .wr_data_dirty_bit(mem_wr_data_dirty_bit),
        .wr_data_evict_way(wr_data_evict_way), .wr_data_state(mem_wr_data_state),
        .rd_data_line(rd_data_line), .rd_data_tag(rd_data_tag),
        .rd_data_sharers(rd_data_sharers), .rd_data_owner(rd_data_owner),
        .rd_data_hprot(rd_data_hprot), .rd_data_dirty_bit(rd_data_dirty_bit),
        .rd_data_evict_way(rd_data_evict_way), .rd_data_state(rd_data_state)
    );

endmodule

`default_nettype wire

// File: verification/llc_tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module llc_tb_clock #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release just after an edge, like the other inputs
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

`default_nettype wire

// File: verification/llc_mem_assert.sv
`timescale 1ns/1ns
`default_nettype none

`include "llc_config.svh"

module llc_mem_assert (
    input logic                 clk,
    input logic                 reset,
    input logic                 flush_busy,
    input logic                 flush_done,
    input logic [`LLC_WAYS-1:0] wr_rst_flush
);

    // done is a one-cycle pulse
    done_single_pulse: assert property (@(posedge clk) disable iff (reset)
        flush_done |=> !flush_done)
        else $error("flush_done held for more than one cycle");

    // done comes with the falling edge of busy, in both directions
    busy_fall_gives_done: assert property (@(posedge clk) disable iff (reset)
        $fell(flush_busy) |-> flush_done)
        else $error("flush_busy fell without flush_done");

    done_needs_busy_fall: assert property (@(posedge clk) disable iff (reset)
        flush_done |-> !flush_busy && $past(flush_busy))
        else $error("flush_done without a walk that just ended");

    idle_mask_zero: assert property (@(posedge clk) disable iff (reset)
        !flush_busy |-> wr_rst_flush == '0)
        else $error("flush way mask active while the sequencer is idle");

    idle_after_reset: assert property (@(posedge clk)
        reset |=> !flush_busy && !flush_done)
        else $error("flush sequencer not idle after reset");

endmodule

bind llc_flush_seq llc_mem_assert u_flush_assert (
    .clk(clk), .reset(reset), .flush_busy(flush_busy), .flush_done(flush_done),
    .wr_rst_flush(wr_rst_flush)
);

`default_nettype wire

// File: verification/llc_mem_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "llc_config.svh"

module llc_mem_tb;
    import llc_pkg::*;

    localparam int N_RANDOM = 200;
    localparam int N_PAIR   = 8;
    localparam int N_FLUSH  = 3;
    localparam int N_OPS    = `LLC_SETS * `LLC_WAYS + 2 * N_RANDOM + 5 * N_PAIR + 8
                              + N_FLUSH * 2 * `LLC_SETS;
    localparam int TIMEOUT_CYCLES = 16 + 2 * N_OPS + N_FLUSH * (`LLC_SETS + 2) + 100;
    localparam llc_set_t BANK_MASK =
        llc_set_t'(((1 << `LLC_BANK_BITS) - 1) << `LLC_IDX_BITS);

    logic                 clk;
    logic                 reset;
    llc_set_t             set;
    llc_way_t             way;
    logic                 rd_en;
    logic                 wr_en;
    logic                 wr_en_evict_way;
    line_t                wr_data_line;
    llc_tag_t             wr_data_tag;
    sharers_t             wr_data_sharers;
    owner_t               wr_data_owner;
    hprot_t               wr_data_hprot;
    logic                 wr_data_dirty_bit;
    llc_way_t             wr_data_evict_way;
    llc_state_t           wr_data_state;
    logic                 flush_start;
    logic [`LLC_WAYS-1:0] flush_ways;
    line_t                rd_data_line [`LLC_WAYS];
    llc_tag_t             rd_data_tag [`LLC_WAYS];
    sharers_t             rd_data_sharers [`LLC_WAYS];
    owner_t               rd_data_owner [`LLC_WAYS];
    hprot_t               rd_data_hprot [`LLC_WAYS];
    logic                 rd_data_dirty_bit [`LLC_WAYS];
    llc_state_t           rd_data_state [`LLC_WAYS];
    llc_way_t             rd_data_evict_way;
    logic                 flush_busy;
    logic                 flush_done;

    // reference contents, [way][set]
    llc_tag_t   m_tag     [`LLC_WAYS][`LLC_SETS];
    line_t      m_line    [`LLC_WAYS][`LLC_SETS];
    sharers_t   m_sharers [`LLC_WAYS][`LLC_SETS];
    owner_t     m_owner   [`LLC_WAYS][`LLC_SETS];
    hprot_t     m_hprot   [`LLC_WAYS][`LLC_SETS];
    logic       m_dirty   [`LLC_WAYS][`LLC_SETS];
    llc_state_t m_state   [`LLC_WAYS][`LLC_SETS];
    llc_way_t   m_evict   [`LLC_SETS];

    // expected outputs, taken when a read is issued
    llc_tag_t   exp_tag     [`LLC_WAYS];
    line_t      exp_line    [`LLC_WAYS];
    sharers_t   exp_sharers [`LLC_WAYS];
    owner_t     exp_owner   [`LLC_WAYS];
    hprot_t     exp_hprot   [`LLC_WAYS];
    logic       exp_dirty   [`LLC_WAYS];
    llc_state_t exp_state   [`LLC_WAYS];
    llc_way_t   exp_evict;

    int cycle_count = 0;

    llc_tb_clock u_clock (.clk(clk), .reset(reset));

    llc_mem_top u_llc_mem_top (.*);

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TESTS FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s actual=%0h expected=%0h",
                     $time, name, actual, expected);
            $display("TESTS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // one cycle with any mix of read, field write and pointer write
    task automatic access(input llc_set_t s, input llc_way_t w, input bit rd,
                          input bit wr, input bit ev);
        set               = s;
        way               = w;
        rd_en             = rd;
        wr_en             = wr;
        wr_en_evict_way   = ev;
        wr_data_line      = {$urandom, $urandom};
        wr_data_tag       = llc_tag_t'($urandom);
        wr_data_sharers   = sharers_t'($urandom);
        wr_data_owner     = owner_t'($urandom);
        wr_data_hprot     = ($urandom_range(1, 0) == 1);
        wr_data_dirty_bit = ($urandom_range(1, 0) == 1);
        wr_data_evict_way = llc_way_t'($urandom);
        wr_data_state     = llc_state_t'($urandom_range(4, 0));
        // read-first, so the snapshot is taken before this write lands
        if (rd) begin
            for (int i = 0; i < `LLC_WAYS; i++) begin
                exp_tag[i]     = m_tag[i][s];
                exp_line[i]    = m_line[i][s];
                exp_sharers[i] = m_sharers[i][s];
                exp_owner[i]   = m_owner[i][s];
                exp_hprot[i]   = m_hprot[i][s];
                exp_dirty[i]   = m_dirty[i][s];
                exp_state[i]   = m_state[i][s];
            end
            exp_evict = m_evict[s];
        end
        next_cycle();
        if (wr) begin
            m_tag[w][s]     = wr_data_tag;
            m_line[w][s]    = wr_data_line;
            m_sharers[w][s] = wr_data_sharers;
            m_owner[w][s]   = wr_data_owner;
            m_hprot[w][s]   = wr_data_hprot;
            m_dirty[w][s]   = wr_data_dirty_bit;
            m_state[w][s]   = wr_data_state;
        end
        if (ev) begin
            m_evict[s] = wr_data_evict_way;
        end
        rd_en           = 1'b0;
        wr_en           = 1'b0;
        wr_en_evict_way = 1'b0;
    endtask

    task automatic check_outputs();
        for (int i = 0; i < `LLC_WAYS; i++) begin
            check_value($sformatf("rd_data_tag[%0d]", i), rd_data_tag[i], exp_tag[i]);
            check_value($sformatf("rd_data_line[%0d]", i), rd_data_line[i], exp_line[i]);
            check_value($sformatf("rd_data_sharers[%0d]", i), rd_data_sharers[i],
                        exp_sharers[i]);
            check_value($sformatf("rd_data_owner[%0d]", i), rd_data_owner[i], exp_owner[i]);
            check_value($sformatf("rd_data_hprot[%0d]", i), rd_data_hprot[i], exp_hprot[i]);
            check_value($sformatf("rd_data_dirty_bit[%0d]", i), rd_data_dirty_bit[i],
                        exp_dirty[i]);
            check_value($sformatf("rd_data_state[%0d]", i), rd_data_state[i], exp_state[i]);
        end
        check_value("rd_data_evict_way", rd_data_evict_way, exp_evict);
    endtask

    task automatic run_flush(input logic [`LLC_WAYS-1:0] mask);
        int busy_cycles;
        busy_cycles = 0;
        flush_ways  = mask;
        flush_start = 1'b1;
        next_cycle();
        flush_start = 1'b0;
        // latched at start, so later changes must not matter
        flush_ways  = ~mask;
        for (int s = 0; s < `LLC_SETS; s++) begin
            for (int w = 0; w < `LLC_WAYS; w++) begin
                if (mask[w]) begin
                    m_state[w][s]   = invalid;
                    m_sharers[w][s] = '0;
                    m_dirty[w][s]   = 1'b0;
                end
            end
        end
        while (flush_busy) begin
            check_value("flush_done", flush_done, 1'b0);
            if (busy_cycles == 4) begin
                set         = llc_set_t'($urandom);
                rd_en       = 1'b1;
                flush_start = 1'b1;
            end
            busy_cycles++;
            next_cycle();
            rd_en       = 1'b0;
            flush_start = 1'b0;
        end
        check_value("flush_busy cycles", busy_cycles, `LLC_SETS);
        check_value("flush_done", flush_done, 1'b1);
        next_cycle();
        check_value("flush_done", flush_done, 1'b0);
        check_value("flush_busy", flush_busy, 1'b0);
        // the read issued while busy was dropped
        check_outputs();
    endtask

    initial begin
        llc_set_t s;
        llc_way_t w;
        logic [`LLC_WAYS-1:0] mask;
        void'($urandom(32'hb9c0));
        set               = '0;
        way               = '0;
        rd_en             = 1'b0;
        wr_en             = 1'b0;
        wr_en_evict_way   = 1'b0;
        wr_data_line      = '0;
        wr_data_tag       = '0;
        wr_data_sharers   = '0;
        wr_data_owner     = '0;
        wr_data_hprot     = 1'b0;
        wr_data_dirty_bit = 1'b0;
        wr_data_evict_way = '0;
        wr_data_state     = invalid;
        flush_start       = 1'b0;
        flush_ways        = '0;
        wait (reset == 1'b0);
        next_cycle();
        check_value("flush_busy", flush_busy, 1'b0);
        check_value("flush_done", flush_done, 1'b0);

        // fill everything once so no RAM word is unknown
        for (int si = 0; si < `LLC_SETS; si++) begin
            for (int wi = 0; wi < `LLC_WAYS; wi++) begin
                access(llc_set_t'(si), llc_way_t'(wi), 1'b0, 1'b1, wi == 0);
            end
        end
        access('0, '0, 1'b1, 1'b0, 1'b0);
        check_outputs();

        // random writes, some with a same-cycle read, then a read back
        for (int n = 0; n < N_RANDOM; n++) begin
            s = llc_set_t'($urandom);
            w = llc_way_t'($urandom);
            access(s, w, $urandom_range(3, 0) == 0, 1'b1, $urandom_range(1, 0) == 1);
            check_outputs();
            access(s, w, 1'b1, 1'b0, 1'b0);
            check_outputs();
        end

        // banks and even/odd partners stay apart
        for (int n = 0; n < N_PAIR; n++) begin
            s = llc_set_t'($urandom);
            w = llc_way_t'($urandom);
            access(s, w, 1'b0, 1'b1, 1'b0);
            access(s, w ^ 1'b1, 1'b0, 1'b1, 1'b0);
            access(s ^ BANK_MASK, w, 1'b0, 1'b1, 1'b0);
            access(s, w, 1'b1, 1'b0, 1'b0);
            check_outputs();
            access(s ^ BANK_MASK, w, 1'b1, 1'b0, 1'b0);
            check_outputs();
        end

        // pointer write alone, then field write alone
        s = llc_set_t'($urandom);
        access(s, '0, 1'b0, 1'b0, 1'b1);
        access(s, '0, 1'b1, 1'b0, 1'b0);
        check_outputs();
        access(s, llc_way_t'($urandom), 1'b0, 1'b1, 1'b0);
        access(s, '0, 1'b1, 1'b0, 1'b0);
        check_outputs();

        // no read, so the outputs hold across writes to the same set
        access(s, llc_way_t'($urandom), 1'b0, 1'b1, 1'b1);
        check_outputs();
        next_cycle();
        check_outputs();

        for (int n = 0; n < N_FLUSH; n++) begin
            for (int j = 0; j < `LLC_SETS; j++) begin
                access(llc_set_t'($urandom), llc_way_t'($urandom), 1'b0, 1'b1, 1'b0);
            end
            mask = $urandom;
            mask[n % `LLC_WAYS] = 1'b1;
            run_flush(mask);
            for (int si = 0; si < `LLC_SETS; si++) begin
                access(llc_set_t'(si), '0, 1'b1, 1'b0, 1'b0);
                check_outputs();
            end
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+hw
hw/llc_pkg.sv
hw/llc_bram_2p.sv
hw/llc_way_pair_mem.sv
hw/llc_localmem.sv
hw/llc_flush_seq.sv
hw/llc_mem_top.sv
verification/llc_tb_clock.sv
verification/llc_mem_assert.sv
verification/llc_mem_tb.sv
